// File: common/coms_pkg.sv
package coms_pkg;

	//////////////////////////////////////////////////////////////////////
	// link dimensions and uart timing
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_MOTORS   = 4;
	localparam int CLKS_PER_BIT = 16;
	localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

	// frame magic numbers, sent msb first
	localparam int          MAGIC_LEN      = 4;
	localparam logic [31:0] REQUEST_MAGIC  = 32'h1CE1_CEBB;
	localparam logic [31:0] STATUS_MAGIC   = 32'h1CEB_00DA;
	localparam logic [31:0] SETPOINT_MAGIC = 32'hD0D0_D0D0;

	// frame lengths in bytes, magic and crc included
	localparam int REQUEST_LEN     = 7;
	localparam int SETPOINT_LEN    = 11;
	localparam int STATUS_LEN      = 23;
	localparam int STATUS_BODY_LEN = STATUS_LEN - MAGIC_LEN;

	// one full status frame plus eight byte times of slack for the turnaround
	localparam int REPLY_WINDOW = (STATUS_LEN + 8) * 10 * CLKS_PER_BIT;
	localparam int REPLY_CNT_W  = $clog2(REPLY_WINDOW);

	typedef logic [1:0] motor_id_t;

	typedef enum logic {
		FRAME_REQUEST,
		FRAME_SETPOINT
	} frame_kind_t;

	localparam logic [31:0] ERR_NONE    = 32'h0000_0000;
	localparam logic [31:0] ERR_CRC     = 32'hBAAD_C0DE;
	localparam logic [31:0] ERR_TIMEOUT = 32'hDEAD_BEAF;

	//////////////////////////////////////////////////////////////////////
	// crc-16, poly x^16+x^15+x^2+1, data msb enters first
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb) begin
				c = c ^ 16'h8005;
			end
		end
		return c;
	endfunction

endpackage

// File: common/tx_cmd_if.sv
`timescale 1ns/1ps

interface tx_cmd_if import coms_pkg::*; ();

	logic               start;
	frame_kind_t        kind;
	motor_id_t          motor;
	logic signed [31:0] setpoint;
	logic               busy;

	// start is a single-cycle strobe, only while busy is low
	modport scheduler (output start, output kind, output motor, output setpoint, input busy);

	modport sender (input start, input kind, input motor, input setpoint, output busy);

endinterface

// File: common/link_if.sv
`timescale 1ns/1ps

interface link_if import coms_pkg::*; ();

	logic      window_open;
	motor_id_t motor;

	// pulse pair, high together for one cycle when telemetry is written
	logic      frame_ok;
	logic      setpoint_mismatch;

	modport scheduler (output window_open, output motor, input frame_ok, input setpoint_mismatch);

	modport receiver (input window_open, input motor, output frame_ok, output setpoint_mismatch);

endinterface

// File: hw/uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import coms_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  byte  data,
	output logic busy,
	output logic tx,
	output logic tx_enable
);

	logic [9:0]           shreg;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [3:0]           bit_cnt;
	logic                 bit_end;

	assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (start) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			// bit 9 is the stop bit
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + BIT_CNT_W'(1);
		end
	end

	// stop, data lsb first, start
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shreg <= {1'b1, data, 1'b0};
		end else if (busy && bit_end) begin
			shreg <= {1'b1, shreg[9:1]};
		end
	end

	assign tx        = busy ? shreg[0] : 1'b1;
	assign tx_enable = busy;

endmodule

// File: hw/uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import coms_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic valid,
	output byte  data
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t            state;
	logic [1:0]           sync;
	logic                 rx_s;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [2:0]           bit_cnt;
	logic [7:0]           shreg;
	logic                 bit_end;

	assign rx_s    = sync[1];
	assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync    <= 2'b11;
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			valid   <= 1'b0;
		end else begin
			sync  <= {sync[0], rx};
			valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (!rx_s) begin
						state   <= RX_START;
						clk_cnt <= '0;
					end
				end
				RX_START: begin
					// half a bit in, the line must still be low
					if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_s ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + BIT_CNT_W'(1);
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + BIT_CNT_W'(1);
					end
				end
				default: begin
					// mid stop bit, a low line here is a framing error
					if (bit_end) begin
						state <= RX_IDLE;
						valid <= rx_s;
					end else begin
						clk_cnt <= clk_cnt + BIT_CNT_W'(1);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end) begin
			shreg <= {rx_s, shreg[7:1]};
		end
	end

	assign data = shreg;

endmodule

// File: hw/poll_scheduler.sv
`timescale 1ns/1ps

module poll_scheduler import coms_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [31:0]        poll_period,
	input  logic signed [31:0] setpoint [NUM_MOTORS],
	tx_cmd_if.scheduler        cmd,
	link_if.scheduler          link
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQUEST,
		S_WINDOW,
		S_SETPOINT
	} sched_state_t;

	sched_state_t           state;
	logic [31:0]            timer;
	logic [REPLY_CNT_W-1:0] win_cnt;
	motor_id_t              motor_r;
	motor_id_t              next_motor;
	logic                   pending;
	logic                   sp_due;
	logic                   issue_req;
	logic                   issue_sp;

	// a mismatch may land on the last window cycle, so look at the live pulse too
	assign sp_due    = pending || (link.frame_ok && link.setpoint_mismatch);
	assign issue_req = (state == S_IDLE) && (timer == '0);
	assign issue_sp  = (state == S_WINDOW) && (win_cnt == '0) && sp_due;

	assign cmd.start    = issue_req || issue_sp;
	assign cmd.kind     = issue_sp ? FRAME_SETPOINT : FRAME_REQUEST;
	assign cmd.motor    = issue_sp ? motor_r : next_motor;
	assign cmd.setpoint = setpoint[motor_r];

	assign link.window_open = (state == S_WINDOW);
	assign link.motor       = motor_r;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= S_IDLE;
			timer      <= '0;
			win_cnt    <= '0;
			motor_r    <= '0;
			next_motor <= '0;
			pending    <= 1'b0;
		end else begin
			if (timer != '0) begin
				timer <= timer - 32'd1;
			end
			case (state)
				S_IDLE: begin
					if (issue_req) begin
						timer      <= (poll_period == '0) ? '0 : poll_period - 32'd1;
						motor_r    <= next_motor;
						next_motor <= (next_motor == motor_id_t'(NUM_MOTORS - 1)) ?
							'0 : next_motor + motor_id_t'(1);
						pending    <= 1'b0;
						state      <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					if (!cmd.busy) begin
						win_cnt <= REPLY_CNT_W'(REPLY_WINDOW - 1);
						state   <= S_WINDOW;
					end
				end
				S_WINDOW: begin
					if (link.frame_ok && link.setpoint_mismatch) begin
						pending <= 1'b1;
					end
					if (win_cnt == '0) begin
						pending <= 1'b0;
						state   <= sp_due ? S_SETPOINT : S_IDLE;
					end else begin
						win_cnt <= win_cnt - REPLY_CNT_W'(1);
					end
				end
				default: begin
					if (!cmd.busy) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/frame_sender.sv
`timescale 1ns/1ps

module frame_sender import coms_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	tx_cmd_if.sender cmd,
	output logic     tx,
	output logic     tx_enable
);

	frame_kind_t        kind_r;
	motor_id_t          motor_r;
	logic signed [31:0] setpoint_r;
	logic [31:0]        magic;
	logic [3:0]         len;
	logic [3:0]         idx;
	logic [3:0]         sp_sel;
	logic [15:0]        crc;
	logic               busy_r;
	logic               last_r;
	logic               uart_start;
	logic               uart_busy;
	byte                tx_byte;

	assign magic = (kind_r == FRAME_SETPOINT) ? SETPOINT_MAGIC : REQUEST_MAGIC;
	assign len   = (kind_r == FRAME_SETPOINT) ? 4'(SETPOINT_LEN) : 4'(REQUEST_LEN);

	// setpoint bytes sit at 5..8, the low two bits of idx-1 give 0..3
	assign sp_sel = idx - 4'd1;

	always_comb begin
		if (idx < 4'(MAGIC_LEN)) begin
			tx_byte = magic[{~idx[1:0], 3'b000} +: 8];
		end else if (idx == len - 4'd2) begin
			tx_byte = crc[15:8];
		end else if (idx == len - 4'd1) begin
			tx_byte = crc[7:0];
		end else if (idx == 4'(MAGIC_LEN)) begin
			tx_byte = {6'b0, motor_r};
		end else begin
			tx_byte = setpoint_r[{~sp_sel[1:0], 3'b000} +: 8];
		end
	end

	// next byte goes out on the first idle cycle of the serializer
	assign uart_start = busy_r && !uart_busy && !last_r;

	always_ff @(posedge clk) begin
		if (cmd.start) begin
			kind_r     <= cmd.kind;
			motor_r    <= cmd.motor;
			setpoint_r <= cmd.setpoint;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_r <= 1'b0;
			last_r <= 1'b0;
			idx    <= '0;
			crc    <= 16'hFFFF;
		end else if (cmd.start) begin
			busy_r <= 1'b1;
			last_r <= 1'b0;
			idx    <= '0;
			crc    <= 16'hFFFF;
		end else if (uart_start) begin
			idx <= idx + 4'd1;
			if (idx >= 4'(MAGIC_LEN) && idx < len - 4'd2) begin
				crc <= crc16_update(crc, tx_byte);
			end
			if (idx == len - 4'd1) begin
				last_r <= 1'b1;
			end
		end else if (last_r && !uart_busy) begin
			busy_r <= 1'b0;
			last_r <= 1'b0;
		end
	end

	assign cmd.busy = busy_r;

	uart_tx i_uart_tx (
		.clk       (clk),
		.reset     (reset),
		.start     (uart_start),
		.data      (tx_byte),
		.busy      (uart_busy),
		.tx        (tx),
		.tx_enable (tx_enable)
	);

endmodule

// File: hw/status_receiver.sv
`timescale 1ns/1ps

module status_receiver import coms_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx,
	input  logic signed [31:0] setpoint [NUM_MOTORS],
	link_if.receiver           link,
	output logic signed [31:0] position [NUM_MOTORS],
	output logic signed [31:0] velocity [NUM_MOTORS],
	output logic signed [31:0] pwm [NUM_MOTORS],
	output logic [31:0]        error_code [NUM_MOTORS]
);

	logic                         rx_valid;
	byte                          rx_data;
	logic                         window_prev;
	logic                         window_fall;
	logic [31:0]                  magic_sr;
	logic                         capturing;
	logic [4:0]                   byte_cnt;
	logic                         check;
	logic                         frame_seen;
	logic [15:0]                  crc;
	logic [8*STATUS_BODY_LEN-1:0] body;
	logic                         good;

	//////////////////////////////////////////////////////////////////////
	// body layout after the magic: id, position, velocity, pwm,
	// setpoint_actual, crc hi, crc lo
	//////////////////////////////////////////////////////////////////////

	assign good = (body[15:0] == crc) && (body[151:144] == {6'b0, link.motor});

	assign window_fall = window_prev && !link.window_open;

	always_ff @(posedge clk) begin
		if (rx_valid && link.window_open && capturing) begin
			body <= {body[8*STATUS_BODY_LEN-9:0], rx_data};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			window_prev            <= 1'b0;
			magic_sr               <= '0;
			capturing              <= 1'b0;
			byte_cnt               <= '0;
			check                  <= 1'b0;
			frame_seen             <= 1'b0;
			crc                    <= 16'hFFFF;
			link.frame_ok          <= 1'b0;
			link.setpoint_mismatch <= 1'b0;
			for (int i = 0; i < NUM_MOTORS; i++) begin
				position[i]   <= '0;
				velocity[i]   <= '0;
				pwm[i]        <= '0;
				error_code[i] <= '0;
			end
		end else begin
			window_prev            <= link.window_open;
			check                  <= 1'b0;
			link.frame_ok          <= 1'b0;
			link.setpoint_mismatch <= 1'b0;

			if (rx_valid && link.window_open) begin
				if (capturing) begin
					byte_cnt <= byte_cnt + 5'd1;
					// the two trailing crc bytes stay out of the checksum
					if (byte_cnt < 5'(STATUS_BODY_LEN - 2)) begin
						crc <= crc16_update(crc, rx_data);
					end
					if (byte_cnt == 5'(STATUS_BODY_LEN - 1)) begin
						capturing <= 1'b0;
						check     <= 1'b1;
					end
				end else if ({magic_sr[23:0], rx_data} == STATUS_MAGIC) begin
					capturing <= 1'b1;
					byte_cnt  <= '0;
					crc       <= 16'hFFFF;
					magic_sr  <= '0;
				end else begin
					magic_sr <= {magic_sr[23:0], rx_data};
				end
			end

			if (check) begin
				frame_seen <= 1'b1;
				if (good) begin
					position[link.motor]   <= body[143:112];
					velocity[link.motor]   <= body[111:80];
					pwm[link.motor]        <= body[79:48];
					error_code[link.motor] <= ERR_NONE;
					link.frame_ok          <= 1'b1;
					link.setpoint_mismatch <= (body[47:16] != setpoint[link.motor]);
				end else begin
					error_code[link.motor] <= ERR_CRC;
				end
			end

			// window closed, drop any partial frame
			if (window_fall) begin
				capturing  <= 1'b0;
				magic_sr   <= '0;
				frame_seen <= 1'b0;
				check      <= 1'b0;
				if (!frame_seen && !check) begin
					error_code[link.motor] <= ERR_TIMEOUT;
				end
			end
		end
	end

	uart_rx i_uart_rx (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.valid (rx_valid),
		.data  (rx_data)
	);

endmodule

// File: hw/coms_top.sv
`timescale 1ns/1ps

module coms_top import coms_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx_i,
	output logic               tx_o,
	output logic               tx_enable,
	input  logic [31:0]        poll_period,
	input  logic signed [31:0] setpoint [NUM_MOTORS],
	output logic signed [31:0] position [NUM_MOTORS],
	output logic signed [31:0] velocity [NUM_MOTORS],
	output logic signed [31:0] pwm [NUM_MOTORS],
	output logic [31:0]        error_code [NUM_MOTORS]
);

	tx_cmd_if i_cmd_if ();
	link_if   i_link_if ();

	poll_scheduler i_poll_scheduler (
		.clk         (clk),
		.reset       (reset),
		.poll_period (poll_period),
		.setpoint    (setpoint),
		.cmd         (i_cmd_if.scheduler),
		.link        (i_link_if.scheduler)
	);

	frame_sender i_frame_sender (
		.clk       (clk),
		.reset     (reset),
		.cmd       (i_cmd_if.sender),
		.tx        (tx_o),
		.tx_enable (tx_enable)
	);

	status_receiver i_status_receiver (
		.clk        (clk),
		.reset      (reset),
		.rx         (rx_i),
		.setpoint   (setpoint),
		.link       (i_link_if.receiver),
		.position   (position),
		.velocity   (velocity),
		.pwm        (pwm),
		.error_code (error_code)
	);

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// released just after the 16th rising edge
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// File: tb/coms_asserts.sv
`timescale 1ns/1ps

module coms_asserts (
	input logic clk,
	input logic reset,
	input logic tx,
	input logic tx_enable,
	input logic start,
	input logic busy,
	input logic window_open,
	input logic cmd_busy
);

	// a released rs-485 driver leaves the line at the stop level
	idle_line_high: assert property (@(posedge clk) disable iff (reset) !tx_enable |-> tx)
		else $error("tx is low while the line driver is off");

	start_when_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else $error("start given while busy is high");

	window_after_frame: assert property (@(posedge clk) disable iff (reset)
		window_open |-> !cmd_busy)
		else $error("reply window open while a frame is still being sent");

endmodule

// uart gets the line checks, scheduler the handshake checks
bind uart_tx coms_asserts i_uart_tx_asserts (
	.clk         (clk),
	.reset       (reset),
	.tx          (tx),
	.tx_enable   (tx_enable),
	.start       (start),
	.busy        (busy),
	.window_open (1'b0),
	.cmd_busy    (1'b0)
);

bind poll_scheduler coms_asserts i_sched_asserts (
	.clk         (clk),
	.reset       (reset),
	.tx          (1'b1),
	.tx_enable   (1'b0),
	.start       (cmd.start),
	.busy        (cmd.busy),
	.window_open (link.window_open),
	.cmd_busy    (cmd.busy)
);

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import coms_pkg::*; ();

	logic               clk;
	logic               reset;
	logic               rx_i;
	logic               tx_o;
	logic               tx_enable;
	logic [31:0]        poll_period;
	logic signed [31:0] setpoint [NUM_MOTORS];
	logic signed [31:0] position [NUM_MOTORS];
	logic signed [31:0] velocity [NUM_MOTORS];
	logic signed [31:0] pwm [NUM_MOTORS];
	logic [31:0]        error_code [NUM_MOTORS];

	// reference model of the telemetry registers
	logic [31:0] exp_position [NUM_MOTORS];
	logic [31:0] exp_velocity [NUM_MOTORS];
	logic [31:0] exp_pwm [NUM_MOTORS];
	logic [31:0] exp_error [NUM_MOTORS];

	int        seed;
	int        num_polls;
	int        polls;
	int        n_bad;
	int        n_silent;
	int        draw;
	int        outcome;
	int        wait_cnt;
	logic      exp_sp;
	logic      mismatch;
	logic      done;
	motor_id_t exp_motor;
	motor_id_t req_motor;

	tb_clock i_tb_clock (
		.clk   (clk),
		.reset (reset)
	);

	coms_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.rx_i        (rx_i),
		.tx_o        (tx_o),
		.tx_enable   (tx_enable),
		.poll_period (poll_period),
		.setpoint    (setpoint),
		.position    (position),
		.velocity    (velocity),
		.pwm         (pwm),
		.error_code  (error_code)
	);

	//////////////////////////////////////////////////////////////////////
	// checking helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_failure();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic wait_tx_enable(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (tx_enable !== level) begin
			if (n == limit) begin
				$display("timeout: %s", what);
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic check_telemetry();
		for (int m = 0; m < NUM_MOTORS; m++) begin
			check_value($sformatf("position[%0d]", m), position[m], exp_position[m]);
			check_value($sformatf("velocity[%0d]", m), velocity[m], exp_velocity[m]);
			check_value($sformatf("pwm[%0d]", m), pwm[m], exp_pwm[m]);
			check_value($sformatf("error_code[%0d]", m), error_code[m], exp_error[m]);
		end
	endtask

	// msb first crc-16 with poly 0x8005 and an all-ones start
	function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		c = crc ^ {b, 8'h00};
		for (int i = 0; i < 8; i++) begin
			c = c[15] ? ((c << 1) ^ 16'h8005) : (c << 1);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// motor-board model, uart side
	//////////////////////////////////////////////////////////////////////

	// samples mid bit on the falling clock edge
	task automatic read_byte(output logic [7:0] b);
		int n;
		n = 0;
		while (tx_o !== 1'b0) begin
			if (n == 4 * CLKS_PER_BIT) begin
				$display("no start bit seen on tx_o");
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (tx_o !== 1'b0) begin
			$display("start bit on tx_o is shorter than half a bit");
			stop_on_failure();
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			b[i] = tx_o;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (tx_o !== 1'b1) begin
			$display("stop bit missing on tx_o");
			stop_on_failure();
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 rx_i = bits[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic read_frame(input logic sp_frame, input motor_id_t m);
		logic [7:0]  b [SETPOINT_LEN];
		logic [7:0]  v;
		logic [15:0] crc;
		int          len;
		len = sp_frame ? SETPOINT_LEN : REQUEST_LEN;
		crc = 16'hFFFF;
		for (int i = 0; i < len; i++) begin
			read_byte(v);
			b[i] = v;
		end
		check_value("frame magic", {b[0], b[1], b[2], b[3]},
			sp_frame ? SETPOINT_MAGIC : REQUEST_MAGIC);
		check_value("frame motor id", {24'h0, b[4]}, {30'h0, m});
		if (sp_frame) begin
			check_value("frame setpoint", {b[5], b[6], b[7], b[8]}, setpoint[m]);
		end
		for (int i = MAGIC_LEN; i < len - 2; i++) begin
			crc = crc_byte(crc, b[i]);
		end
		check_value("frame crc", {16'h0, b[len-2], b[len-1]}, {16'h0, crc});
		wait_tx_enable(1'b0, 2 * CLKS_PER_BIT, "tx_enable still high after the frame length");
		// tx_enable also drops for one cycle between bytes
		repeat (2 * CLKS_PER_BIT) begin
			@(negedge clk);
			check_value("tx_enable", {31'h0, tx_enable}, 32'h0);
		end
	endtask

	// kind 0 is a good frame, 1 a corrupted crc and 2 silence
	task automatic answer_request(input motor_id_t m, input int kind, output logic sp_diff);
		logic [8*(STATUS_LEN-2)-1:0] payload;
		logic [31:0]                 pos;
		logic [31:0]                 vel;
		logic [31:0]                 pw;
		logic [31:0]                 sp_act;
		logic [15:0]                 crc;
		logic [7:0]                  b;
		sp_diff = 1'b0;
		if (kind == 2) begin
			exp_error[m] = ERR_TIMEOUT;
			return;
		end
		pos = $random(seed);
		vel = $random(seed);
		pw  = $random(seed);
		sp_diff = ($unsigned($random(seed)) % 3) == 0;
		sp_act = setpoint[m];
		if (sp_diff) begin
			sp_act = sp_act + 32'd1 + ($unsigned($random(seed)) & 32'hFF);
		end
		payload = {STATUS_MAGIC, 6'h0, m, pos, vel, pw, sp_act};
		crc = 16'hFFFF;
		for (int i = 0; i < STATUS_LEN - 2; i++) begin
			b = payload[8 * (STATUS_LEN - 3 - i) +: 8];
			if (i >= MAGIC_LEN) begin
				crc = crc_byte(crc, b);
			end
			send_byte(b);
		end
		if (kind == 1) begin
			crc = (($random(seed) & 1) != 0) ? (crc ^ 16'hFF00) : (crc ^ 16'h00FF);
			sp_diff = 1'b0;
			exp_error[m] = ERR_CRC;
		end else begin
			exp_position[m] = pos;
			exp_velocity[m] = vel;
			exp_pwm[m]      = pw;
			exp_error[m]    = ERR_NONE;
		end
		send_byte(crc[15:8]);
		send_byte(crc[7:0]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus and frame sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed        = 32'ha602_d677;
		num_polls   = 24;
		rx_i        = 1'b1;
		poll_period = 32'd9000;
		for (int m = 0; m < NUM_MOTORS; m++) begin
			setpoint[m]     = $random(seed);
			exp_position[m] = '0;
			exp_velocity[m] = '0;
			exp_pwm[m]      = '0;
			exp_error[m]    = '0;
		end

		wait_cnt = 0;
		while (reset !== 1'b0) begin
			if (wait_cnt == 100) begin
				$display("timeout: reset never released");
				stop_on_failure();
			end
			@(negedge clk);
			wait_cnt++;
		end
		@(negedge clk);
		check_value("tx_o", {31'h0, tx_o}, 32'h1);
		check_value("tx_enable", {31'h0, tx_enable}, 32'h0);
		check_telemetry();

		polls     = 0;
		n_bad     = 0;
		n_silent  = 0;
		exp_sp    = 1'b0;
		exp_motor = '0;
		req_motor = '0;
		done      = 1'b0;
		while (!done) begin
			wait_tx_enable(1'b1, 30000, "no frame started on tx_o");
			// earlier replies have all landed by the next frame
			check_telemetry();
			if (polls == num_polls) begin
				done = 1'b1;
			end else begin
				read_frame(exp_sp, exp_motor);
				if (exp_sp) begin
					exp_sp    = 1'b0;
					exp_motor = req_motor;
				end else begin
					draw = $unsigned($random(seed)) % 6;
					outcome = (draw == 0) ? 1 : ((draw == 1) ? 2 : 0);
					if (polls == num_polls - 2 && n_bad == 0) begin
						outcome = 1;
					end
					if (polls == num_polls - 1 && n_silent == 0) begin
						outcome = 2;
					end
					if (outcome == 1) begin
						n_bad++;
					end
					if (outcome == 2) begin
						n_silent++;
					end
					answer_request(exp_motor, outcome, mismatch);
					polls++;
					req_motor = (req_motor == motor_id_t'(NUM_MOTORS - 1)) ?
						'0 : req_motor + motor_id_t'(1);
					if (mismatch) begin
						exp_sp = 1'b1;
					end else begin
						exp_motor = req_motor;
					end
				end
			end
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: tb.f
common/coms_pkg.sv
common/tx_cmd_if.sv
common/link_if.sv
hw/uart/uart_tx.sv
hw/uart/uart_rx.sv
hw/poll_scheduler.sv
hw/frame_sender.sv
hw/status_receiver.sv
hw/coms_top.sv
tb/tb_clock.sv
tb/coms_asserts.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# compile and run the coms testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
exit 1
